// ==== project.f ====
+incdir+design
design/axi_chan_pkg.sv
design/sram_port_pkg.sv
design/sram_req_if.sv
design/chan_fifo.sv
design/axi_write_engine.sv
design/axi_read_engine.sv
design/sram_port_arbiter.sv
design/axi_sram_bridge.sv
sim/sram_behav_model.sv
sim/tb_axi_sram_bridge.sv

// ==== sim/tb_axi_sram_bridge.sv ====
`timescale 1ns/1ps
`include "axi_sram_settings.svh"

module tb_axi_sram_bridge;

    localparam int OP_WR    = 0;
    localparam int OP_RD    = 1;
    localparam int OP_BOTH  = 2;
    localparam int MAX_ROWS = 16;
    localparam int TIMEOUT  = 200;
    localparam int WORDS    = 1 << `SRAM_ADDR_W;

    logic                     ACLK;
    logic                     ARESETn;
    logic [`AXI_ID_W-1:0]     awid_i;
    logic [`AXI_ADDR_W-1:0]   awaddr_i;
    logic [`AXI_LEN_W-1:0]    awlen_i;
    logic                     awvalid_i;
    logic                     awready_o;
    logic [`AXI_DATA_W-1:0]   wdata_i;
    logic [`AXI_DATA_W/8-1:0] wstrb_i;
    logic                     wlast_i;
    logic                     wvalid_i;
    logic                     wready_o;
    logic [`AXI_ID_W-1:0]     bid_o;
    logic [1:0]               bresp_o;
    logic                     bvalid_o;
    logic                     bready_i;
    logic [`AXI_ID_W-1:0]     arid_i;
    logic [`AXI_ADDR_W-1:0]   araddr_i;
    logic [`AXI_LEN_W-1:0]    arlen_i;
    logic                     arvalid_i;
    logic                     arready_o;
    logic [`AXI_ID_W-1:0]     rid_o;
    logic [`AXI_DATA_W-1:0]   rdata_o;
    logic [1:0]               rresp_o;
    logic                     rlast_o;
    logic                     rvalid_o;
    logic                     rready_i;
    logic                     sram_cen;
    logic                     sram_wen;
    logic [`SRAM_ADDR_W-1:0]  sram_addr;
    logic [`AXI_DATA_W-1:0]   sram_wdata;
    logic [`AXI_DATA_W/8-1:0] sram_be;
    logic [`AXI_DATA_W-1:0]   sram_rdata;

    // Stimulus table with one row per burst or burst pair
    string       row_name  [MAX_ROWS];
    int          row_op    [MAX_ROWS];
    logic [3:0]  row_id    [MAX_ROWS];
    logic [31:0] row_addr  [MAX_ROWS];
    logic [31:0] row_raddr [MAX_ROWS];
    int          row_len   [MAX_ROWS];
    logic [31:0] row_base  [MAX_ROWS];
    logic [3:0]  row_strb  [MAX_ROWS];
    bit          row_stall [MAX_ROWS];
    int          num_rows;

    logic [31:0] shadow [WORDS];
    logic [31:0] beat_data [16];
    logic [63:0] rbp;
    logic [63:0] bbp;
    bit          cur_stall;
    integer      seed;
    int          check_count;
    int          error_count;
    int          timeout_count;

    axi_sram_bridge i_axi_sram_bridge
    (
        .ACLK (ACLK), .ARESETn (ARESETn),
        .awid_i (awid_i), .awaddr_i (awaddr_i), .awlen_i (awlen_i),
        .awvalid_i (awvalid_i), .awready_o (awready_o),
        .wdata_i (wdata_i), .wstrb_i (wstrb_i), .wlast_i (wlast_i),
        .wvalid_i (wvalid_i), .wready_o (wready_o),
        .bid_o (bid_o), .bresp_o (bresp_o), .bvalid_o (bvalid_o), .bready_i (bready_i),
        .arid_i (arid_i), .araddr_i (araddr_i), .arlen_i (arlen_i),
        .arvalid_i (arvalid_i), .arready_o (arready_o),
        .rid_o (rid_o), .rdata_o (rdata_o), .rresp_o (rresp_o), .rlast_o (rlast_o),
        .rvalid_o (rvalid_o), .rready_i (rready_i),
        .sram_cen_o (sram_cen), .sram_wen_o (sram_wen), .sram_addr_o (sram_addr),
        .sram_wdata_o (sram_wdata), .sram_be_o (sram_be), .sram_rdata_i (sram_rdata)
    );

    sram_behav_model i_sram_model
    (
        .ACLK (ACLK), .cen_i (sram_cen), .wen_i (sram_wen), .addr_i (sram_addr),
        .wdata_i (sram_wdata), .be_i (sram_be), .rdata_o (sram_rdata)
    );

    initial
    begin
        ACLK = 1'b0;
        forever #2 ACLK = ~ACLK;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] fill_word(input int a);
        return {3'b101, a[12:0], 3'b010, a[12:0]};
    endfunction

    function automatic int word_of(input logic [31:0] addr, input int k);
        return (int'(addr[`SRAM_ADDR_W+1:2]) + k) % WORDS;
    endfunction

    task automatic add_row(input string name, input int op, input logic [3:0] id,
                           input logic [31:0] addr, input logic [31:0] raddr, input int len,
                           input logic [31:0] base, input logic [3:0] strb, input bit stall);
        row_name[num_rows]  = name;
        row_op[num_rows]    = op;
        row_id[num_rows]    = id;
        row_addr[num_rows]  = addr;
        row_raddr[num_rows] = raddr;
        row_len[num_rows]   = len;
        row_base[num_rows]  = base;
        row_strb[num_rows]  = strb;
        row_stall[num_rows] = stall;
        num_rows++;
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("[FAIL] %s %s expected %h actual %h", name, field, expected, actual);
        end
    endtask

    task automatic report_timeout(input string name, input string channel);
        timeout_count++;
        $display("Test %s stalled: no progress on the %s channel within %0d cycles",
                 name, channel, TIMEOUT);
    endtask

    // ------------------------------
    // Burst tasks are entered 1 ns after a rising edge
    // ------------------------------
    task automatic write_burst(input string name, input logic [3:0] id,
                               input logic [31:0] addr, input int len, input logic [3:0] strb);
        int cyc;
        int k;
        int b;
        int bp;
        bit got;
        awid_i    = id;
        awaddr_i  = addr;
        awlen_i   = 8'(len);
        awvalid_i = 1'b1;
        cyc = 0;
        while (!awready_o && cyc < TIMEOUT)
        begin
            @(posedge ACLK);
            #1;
            cyc++;
        end
        if (!awready_o)
        begin
            awvalid_i = 1'b0;
            report_timeout(name, "AW");
            return;
        end
        @(posedge ACLK);
        #1;
        awvalid_i = 1'b0;
        for (k = 0; k <= len; k++)
        begin
            wdata_i  = beat_data[k];
            wstrb_i  = strb;
            wlast_i  = (k == len);
            wvalid_i = 1'b1;
            cyc = 0;
            while (!wready_o && cyc < TIMEOUT)
            begin
                @(posedge ACLK);
                #1;
                cyc++;
            end
            if (!wready_o)
            begin
                wvalid_i = 1'b0;
                report_timeout(name, "W");
                return;
            end
            // Merge the enabled bytes into the expected memory image
            for (b = 0; b < 4; b++)
                if (strb[b])
                    shadow[word_of(addr, k)][8*b +: 8] = beat_data[k][8*b +: 8];
            @(posedge ACLK);
            #1;
        end
        wvalid_i = 1'b0;
        got = 1'b0;
        cyc = 0;
        bp  = 0;
        while (!got && cyc < TIMEOUT)
        begin
            bready_i = !cur_stall || bbp[bp % 64];
            bp++;
            if (bvalid_o && bready_i)
            begin
                check_value(name, "bid", 32'(id), 32'(bid_o));
                check_value(name, "bresp", 32'd0, 32'(bresp_o));
                got = 1'b1;
            end
            cyc++;
            @(posedge ACLK);
            #1;
        end
        // Extra responses stay in the B FIFO where later checks see them
        bready_i = 1'b0;
        if (!got)
            report_timeout(name, "B");
    endtask

    task automatic read_burst(input string name, input logic [3:0] id,
                              input logic [31:0] addr, input int len);
        int cyc;
        int beat;
        int bp;
        arid_i    = id;
        araddr_i  = addr;
        arlen_i   = 8'(len);
        arvalid_i = 1'b1;
        cyc = 0;
        while (!arready_o && cyc < TIMEOUT)
        begin
            @(posedge ACLK);
            #1;
            cyc++;
        end
        if (!arready_o)
        begin
            arvalid_i = 1'b0;
            report_timeout(name, "AR");
            return;
        end
        @(posedge ACLK);
        #1;
        arvalid_i = 1'b0;
        beat = 0;
        cyc  = 0;
        bp   = 0;
        while (beat <= len && cyc < TIMEOUT)
        begin
            rready_i = !cur_stall || rbp[bp % 64];
            bp++;
            if (rvalid_o && rready_i)
            begin
                check_value(name, "rdata", shadow[word_of(addr, beat)], rdata_o);
                check_value(name, "rid", 32'(id), 32'(rid_o));
                check_value(name, "rresp", 32'd0, 32'(rresp_o));
                check_value(name, "rlast", 32'(beat == len), 32'(rlast_o));
                beat++;
                cyc = 0;
            end
            else
            begin
                cyc++;
            end
            @(posedge ACLK);
            #1;
        end
        // Extra beats stay in the R FIFO where later checks see them
        rready_i = 1'b0;
        if (beat <= len)
            report_timeout(name, "R");
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial
    begin
        int row;
        int k;
        seed          = 58;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        num_rows      = 0;
        ARESETn   = 1'b0;
        awid_i    = '0;
        awaddr_i  = '0;
        awlen_i   = '0;
        awvalid_i = 1'b0;
        wdata_i   = '0;
        wstrb_i   = '0;
        wlast_i   = 1'b0;
        wvalid_i  = 1'b0;
        bready_i  = 1'b0;
        arid_i    = '0;
        araddr_i  = '0;
        arlen_i   = '0;
        arvalid_i = 1'b0;
        rready_i  = 1'b0;
        for (k = 0; k < WORDS; k++)
            shadow[k] = fill_word(k);

        add_row("single_write",  OP_WR,   4'h1, 32'h100, 32'h0,   0, 32'h1111_0000, 4'hF, 0);
        add_row("single_read",   OP_RD,   4'h2, 32'h100, 32'h0,   0, 32'h0,         4'hF, 0);
        add_row("burst_write",   OP_WR,   4'h3, 32'h200, 32'h0,   3, 32'h2222_0000, 4'hF, 0);
        add_row("burst_read",    OP_RD,   4'h4, 32'h200, 32'h0,   3, 32'h0,         4'hF, 0);
        add_row("partial_write", OP_WR,   4'h5, 32'h204, 32'h0,   1, 32'h3333_0000, 4'h5, 0);
        add_row("partial_read",  OP_RD,   4'h6, 32'h200, 32'h0,   3, 32'h0,         4'hF, 0);
        add_row("id_write",      OP_WR,   4'hA, 32'h300, 32'h0,   2, 32'h4444_0000, 4'hF, 0);
        add_row("id_read",       OP_RD,   4'hF, 32'h300, 32'h0,   2, 32'h0,         4'hF, 0);
        add_row("stall_write",   OP_WR,   4'h7, 32'h400, 32'h0,   7, 32'h5555_0000, 4'hF, 1);
        add_row("stall_read",    OP_RD,   4'h8, 32'h400, 32'h0,   7, 32'h0,         4'hF, 1);
        add_row("both_ways",     OP_BOTH, 4'h9, 32'h500, 32'h400, 5, 32'h6666_0000, 4'hF, 1);
        add_row("fill_read",     OP_RD,   4'h0, 32'h1000, 32'h0,  1, 32'h0,         4'hF, 0);

        repeat (2) @(posedge ACLK);
        #1;
        ARESETn = 1'b1;
        @(posedge ACLK);
        #1;
        check_value("reset", "awready", 32'd1, 32'(awready_o));
        check_value("reset", "wready", 32'd1, 32'(wready_o));
        check_value("reset", "arready", 32'd1, 32'(arready_o));
        check_value("reset", "bvalid", 32'd0, 32'(bvalid_o));
        check_value("reset", "rvalid", 32'd0, 32'(rvalid_o));
        check_value("reset", "sram_cen", 32'd1, 32'(sram_cen));

        for (row = 0; row < num_rows && timeout_count == 0; row++)
        begin
            cur_stall = row_stall[row];
            for (k = 0; k < 16; k++)
                beat_data[k] = row_base[row] ^ $random(seed);
            rbp = {$random(seed), $random(seed)};
            bbp = {$random(seed), $random(seed)};
            case (row_op[row])
                OP_WR:
                    write_burst(row_name[row], row_id[row], row_addr[row], row_len[row],
                                row_strb[row]);
                OP_RD:
                    read_burst(row_name[row], row_id[row], row_addr[row], row_len[row]);
                default:
                    fork
                        write_burst(row_name[row], row_id[row], row_addr[row], row_len[row],
                                    row_strb[row]);
                        read_burst(row_name[row], row_id[row] + 4'd1, row_raddr[row],
                                   row_len[row]);
                    join
            endcase
            @(posedge ACLK);
            #1;
        end

        // Leftover beats would mean a duplicate
        check_value("drain", "bvalid", 32'd0, 32'(bvalid_o));
        check_value("drain", "rvalid", 32'd0, 32'(rvalid_o));

        $display("Checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== sim/sram_behav_model.sv ====
`timescale 1ns/1ps
`include "axi_sram_settings.svh"

// Single-port SRAM, active low enables, data out one cycle after a read
module sram_behav_model
(
    input  logic                     ACLK,
    input  logic                     cen_i,
    input  logic                     wen_i,
    input  logic [`SRAM_ADDR_W-1:0]  addr_i,
    input  logic [`AXI_DATA_W-1:0]   wdata_i,
    input  logic [`AXI_DATA_W/8-1:0] be_i,
    output logic [`AXI_DATA_W-1:0]   rdata_o
);

    localparam int WORDS = 1 << `SRAM_ADDR_W;

    logic [`AXI_DATA_W-1:0] mem [WORDS];

    // Every word starts with a pattern built from its full address
    initial
    begin
        for (int a = 0; a < WORDS; a++)
            mem[a] = {3'b101, a[12:0], 3'b010, a[12:0]};
    end

    always @(posedge ACLK)
    begin
        if (!cen_i)
        begin
            if (!wen_i)
            begin
                for (int b = 0; b < `AXI_DATA_W / 8; b++)
                    if (be_i[b])
                        mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
            end
            else
            begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

// ==== design/axi_sram_bridge.sv ====
`timescale 1ns/1ps
`include "axi_sram_settings.svh"

module axi_sram_bridge
(
    input  logic                      ACLK,
    input  logic                      ARESETn,

    // ------------------------------
    // AXI write side
    // ------------------------------
    input  axi_chan_pkg::axi_id_t     awid_i,
    input  axi_chan_pkg::axi_addr_t   awaddr_i,
    input  axi_chan_pkg::axi_len_t    awlen_i,
    input  logic                      awvalid_i,
    output logic                      awready_o,

    input  logic [`AXI_DATA_W-1:0]    wdata_i,
    input  logic [`AXI_DATA_W/8-1:0]  wstrb_i,
    input  logic                      wlast_i,
    input  logic                      wvalid_i,
    output logic                      wready_o,

    output axi_chan_pkg::axi_id_t     bid_o,
    output axi_chan_pkg::axi_resp_t   bresp_o,
    output logic                      bvalid_o,
    input  logic                      bready_i,

    // ------------------------------
    // AXI read side
    // ------------------------------
    input  axi_chan_pkg::axi_id_t     arid_i,
    input  axi_chan_pkg::axi_addr_t   araddr_i,
    input  axi_chan_pkg::axi_len_t    arlen_i,
    input  logic                      arvalid_i,
    output logic                      arready_o,

    output axi_chan_pkg::axi_id_t     rid_o,
    output logic [`AXI_DATA_W-1:0]    rdata_o,
    output axi_chan_pkg::axi_resp_t   rresp_o,
    output logic                      rlast_o,
    output logic                      rvalid_o,
    input  logic                      rready_i,

    // Single-port SRAM
    output logic                      sram_cen_o,
    output logic                      sram_wen_o,
    output sram_port_pkg::sram_addr_t sram_addr_o,
    output sram_port_pkg::sram_word_t sram_wdata_o,
    output sram_port_pkg::sram_be_t   sram_be_o,
    input  sram_port_pkg::sram_word_t sram_rdata_i
);
    import axi_chan_pkg::*;

    localparam int FREE_W = $clog2(`CHAN_FIFO_DEPTH + 1);

    ax_beat_t          aw_in;
    ax_beat_t          aw_out;
    logic              aw_valid;
    logic              aw_ready;
    w_beat_t           w_in;
    w_beat_t           w_out;
    logic              w_valid;
    logic              w_ready;
    b_beat_t           b_in;
    b_beat_t           b_out;
    logic              b_valid;
    logic              b_ready;
    ax_beat_t          ar_in;
    ax_beat_t          ar_out;
    logic              ar_valid;
    logic              ar_ready;
    r_beat_t           r_in;
    r_beat_t           r_out;
    logic              r_valid;
    logic [FREE_W-1:0] r_free;

    sram_req_if wr_req ();
    sram_req_if rd_req ();

    // Flat ports to channel structs and back
    assign aw_in = '{id: awid_i, addr: awaddr_i, len: awlen_i};
    assign w_in  = '{data: wdata_i, strb: wstrb_i, last: wlast_i};
    assign ar_in = '{id: arid_i, addr: araddr_i, len: arlen_i};

    assign bid_o   = b_out.id;
    assign bresp_o = b_out.resp;
    assign rid_o   = r_out.id;
    assign rdata_o = r_out.data;
    assign rresp_o = r_out.resp;
    assign rlast_o = r_out.last;

    // ------------------------------
    // Channel buffers
    // ------------------------------
    chan_fifo #(.payload_t (ax_beat_t), .DEPTH (`CHAN_FIFO_DEPTH)) fifo_aw
    (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .in_valid_i  (awvalid_i),
        .in_data_i   (aw_in),
        .in_ready_o  (awready_o),
        .out_valid_o (aw_valid),
        .out_data_o  (aw_out),
        .out_ready_i (aw_ready),
        .free_o      ()
    );

    chan_fifo #(.payload_t (w_beat_t), .DEPTH (`CHAN_FIFO_DEPTH)) fifo_w
    (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .in_valid_i  (wvalid_i),
        .in_data_i   (w_in),
        .in_ready_o  (wready_o),
        .out_valid_o (w_valid),
        .out_data_o  (w_out),
        .out_ready_i (w_ready),
        .free_o      ()
    );

    chan_fifo #(.payload_t (b_beat_t), .DEPTH (`CHAN_FIFO_DEPTH)) fifo_b
    (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .in_valid_i  (b_valid),
        .in_data_i   (b_in),
        .in_ready_o  (b_ready),
        .out_valid_o (bvalid_o),
        .out_data_o  (b_out),
        .out_ready_i (bready_i),
        .free_o      ()
    );

    chan_fifo #(.payload_t (ax_beat_t), .DEPTH (`CHAN_FIFO_DEPTH)) fifo_ar
    (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .in_valid_i  (arvalid_i),
        .in_data_i   (ar_in),
        .in_ready_o  (arready_o),
        .out_valid_o (ar_valid),
        .out_data_o  (ar_out),
        .out_ready_i (ar_ready),
        .free_o      ()
    );

    // Read engine never pushes without a free slot
    chan_fifo #(.payload_t (r_beat_t), .DEPTH (`CHAN_FIFO_DEPTH)) fifo_r
    (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .in_valid_i  (r_valid),
        .in_data_i   (r_in),
        .in_ready_o  (),
        .out_valid_o (rvalid_o),
        .out_data_o  (r_out),
        .out_ready_i (rready_i),
        .free_o      (r_free)
    );

    // ------------------------------
    // Engines and port arbiter
    // ------------------------------
    axi_write_engine i_write_engine
    (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .aw_valid_i (aw_valid),
        .aw_beat_i  (aw_out),
        .aw_ready_o (aw_ready),
        .w_valid_i  (w_valid),
        .w_beat_i   (w_out),
        .w_ready_o  (w_ready),
        .b_valid_o  (b_valid),
        .b_beat_o   (b_in),
        .b_ready_i  (b_ready),
        .mem        (wr_req.engine)
    );

    axi_read_engine i_read_engine
    (
        .ACLK         (ACLK),
        .ARESETn      (ARESETn),
        .ar_valid_i   (ar_valid),
        .ar_beat_i    (ar_out),
        .ar_ready_o   (ar_ready),
        .r_valid_o    (r_valid),
        .r_beat_o     (r_in),
        .r_free_i     (r_free),
        .sram_rdata_i (sram_rdata_i),
        .mem          (rd_req.engine)
    );

    sram_port_arbiter i_port_arbiter
    (
        .ACLK         (ACLK),
        .ARESETn      (ARESETn),
        .wr           (wr_req.arbiter),
        .rd           (rd_req.arbiter),
        .sram_cen_o   (sram_cen_o),
        .sram_wen_o   (sram_wen_o),
        .sram_addr_o  (sram_addr_o),
        .sram_wdata_o (sram_wdata_o),
        .sram_be_o    (sram_be_o)
    );

endmodule

// ==== design/sram_port_arbiter.sv ====
`timescale 1ns/1ps

module sram_port_arbiter
(
    input  logic                      ACLK,
    input  logic                      ARESETn,

    sram_req_if.arbiter               wr,
    sram_req_if.arbiter               rd,

    // SRAM pins, cen and wen active low
    output logic                      sram_cen_o,
    output logic                      sram_wen_o,
    output sram_port_pkg::sram_addr_t sram_addr_o,
    output sram_port_pkg::sram_word_t sram_wdata_o,
    output sram_port_pkg::sram_be_t   sram_be_o
);

    logic rr_flag_q;
    logic grant_wr;
    logic grant_rd;

    // Flag low favours write, flag high favours read
    assign grant_wr = wr.req_valid && (!rr_flag_q || !rd.req_valid);
    assign grant_rd = rd.req_valid && (rr_flag_q || !wr.req_valid);

    assign wr.grant = grant_wr;
    assign rd.grant = grant_rd;

    // ------------------------------
    // Pin multiplexer
    // ------------------------------
    always_comb
    begin
        sram_cen_o = !(grant_wr || grant_rd);
        if (grant_rd)
        begin
            // Read engine presents full byte enables
            sram_wen_o   = !rd.we;
            sram_addr_o  = rd.addr;
            sram_wdata_o = rd.wdata;
            sram_be_o    = rd.be;
        end
        else
        begin
            sram_wen_o   = !wr.we;
            sram_addr_o  = wr.addr;
            sram_wdata_o = wr.wdata;
            sram_be_o    = wr.be;
        end
    end

    // Swap priority after every access
    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
            rr_flag_q <= 1'b0;
        else if (!sram_cen_o)
            rr_flag_q <= !rr_flag_q;
    end

endmodule

// ==== design/axi_read_engine.sv ====
`timescale 1ns/1ps
`include "axi_sram_settings.svh"

module axi_read_engine
(
    input  logic                                  ACLK,
    input  logic                                  ARESETn,

    // Burst address from the AR FIFO
    input  logic                                  ar_valid_i,
    input  axi_chan_pkg::ax_beat_t                ar_beat_i,
    output logic                                  ar_ready_o,

    // Beats into the R FIFO, room is judged from its free count
    output logic                                  r_valid_o,
    output axi_chan_pkg::r_beat_t                 r_beat_o,
    input  logic [$clog2(`CHAN_FIFO_DEPTH+1)-1:0] r_free_i,

    input  sram_port_pkg::sram_word_t             sram_rdata_i,
    sram_req_if.engine                            mem
);
    import axi_chan_pkg::*;
    import sram_port_pkg::*;

    localparam int FREE_W = $clog2(`CHAN_FIFO_DEPTH + 1);

    logic       busy_q;
    logic       issue_done_q;
    logic       cap_q;
    axi_id_t    id_q;
    axi_len_t   len_q;
    axi_len_t   issue_idx_q;
    axi_len_t   cap_idx_q;
    sram_addr_t addr_q;
    logic       ar_fire;
    logic       rd_fire;
    logic       last_cap;

    assign ar_ready_o = !busy_q;
    assign ar_fire    = ar_valid_i && ar_ready_o;

    // ------------------------------
    // SRAM read request
    // ------------------------------
    // A beat returning this cycle still needs its own slot
    assign mem.req_valid = busy_q && !issue_done_q && (r_free_i > FREE_W'(cap_q));
    assign mem.we        = 1'b0;
    assign mem.addr      = addr_q;
    assign mem.wdata     = '0;
    assign mem.be        = '1;

    assign rd_fire = mem.req_valid && mem.grant;

    // Data arrives one cycle after our grant and goes straight into the FIFO
    assign last_cap  = (cap_idx_q == len_q);
    assign r_valid_o = cap_q;
    assign r_beat_o  = '{id: id_q, data: sram_rdata_i, resp: RESP_OKAY, last: last_cap};

    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            busy_q       <= 1'b0;
            issue_done_q <= 1'b0;
            cap_q        <= 1'b0;
            issue_idx_q  <= '0;
            cap_idx_q    <= '0;
        end
        else
        begin
            cap_q <= rd_fire;
            if (ar_fire)
            begin
                busy_q       <= 1'b1;
                issue_done_q <= 1'b0;
                issue_idx_q  <= '0;
                cap_idx_q    <= '0;
            end
            else
            begin
                if (rd_fire)
                begin
                    issue_idx_q <= issue_idx_q + 1'b1;
                    if (issue_idx_q == len_q)
                        issue_done_q <= 1'b1;
                end
                // Burst ends when its last beat is captured
                if (cap_q)
                begin
                    cap_idx_q <= cap_idx_q + 1'b1;
                    if (last_cap)
                        busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge ACLK)
    begin
        if (ar_fire)
        begin
            id_q   <= ar_beat_i.id;
            len_q  <= ar_beat_i.len;
            addr_q <= ar_beat_i.addr[WORD_BYTES_LOG2 +: $bits(sram_addr_t)];
        end
        else if (rd_fire)
        begin
            addr_q <= addr_q + 1'b1;
        end
    end

endmodule

// ==== design/axi_write_engine.sv ====
`timescale 1ns/1ps

module axi_write_engine
(
    input  logic                   ACLK,
    input  logic                   ARESETn,

    // Burst address from the AW FIFO
    input  logic                   aw_valid_i,
    input  axi_chan_pkg::ax_beat_t aw_beat_i,
    output logic                   aw_ready_o,

    // Data beats from the W FIFO
    input  logic                   w_valid_i,
    input  axi_chan_pkg::w_beat_t  w_beat_i,
    output logic                   w_ready_o,

    // Response into the B FIFO
    output logic                   b_valid_o,
    output axi_chan_pkg::b_beat_t  b_beat_o,
    input  logic                   b_ready_i,

    sram_req_if.engine             mem
);
    import axi_chan_pkg::*;
    import sram_port_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_DATA, S_RESP} wr_state_e;

    wr_state_e  state_q;
    wr_state_e  state_d;
    axi_id_t    id_q;
    sram_addr_t addr_q;
    logic       aw_fire;
    logic       w_fire;

    // A new burst waits for room in the B FIFO
    assign aw_ready_o = (state_q == S_IDLE) && b_ready_i;
    assign aw_fire    = aw_valid_i && aw_ready_o;

    // ------------------------------
    // SRAM write request
    // ------------------------------
    assign mem.req_valid = (state_q == S_DATA) && w_valid_i;
    assign mem.we        = 1'b1;
    assign mem.addr      = addr_q;
    assign mem.wdata     = w_beat_i.data;
    assign mem.be        = w_beat_i.strb;

    // W beat leaves the FIFO in the grant cycle
    assign w_fire    = mem.req_valid && mem.grant;
    assign w_ready_o = w_fire;

    assign b_valid_o = (state_q == S_RESP);
    assign b_beat_o  = '{id: id_q, resp: RESP_OKAY};

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            S_IDLE:
                if (aw_fire)
                    state_d = S_DATA;
            S_DATA:
                if (w_fire && w_beat_i.last)
                    state_d = S_RESP;
            S_RESP:
                if (b_ready_i)
                    state_d = S_IDLE;
            default:
                state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
            state_q <= S_IDLE;
        else
            state_q <= state_d;
    end

    // Beat k goes to the start word plus k
    always_ff @(posedge ACLK)
    begin
        if (aw_fire)
        begin
            id_q   <= aw_beat_i.id;
            addr_q <= aw_beat_i.addr[WORD_BYTES_LOG2 +: $bits(sram_addr_t)];
        end
        else if (w_fire)
        begin
            addr_q <= addr_q + 1'b1;
        end
    end

endmodule

// ==== design/chan_fifo.sv ====
`timescale 1ns/1ps

module chan_fifo
#(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
)
(
    input  logic                         ACLK,
    input  logic                         ARESETn,

    input  logic                         in_valid_i,
    input  payload_t                     in_data_i,
    output logic                         in_ready_o,

    output logic                         out_valid_o,
    output payload_t                     out_data_o,
    input  logic                         out_ready_i,

    output logic [$clog2(DEPTH+1)-1:0]   free_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    assign in_ready_o  = (count_q != CNT_W'(DEPTH));
    assign out_valid_o = (count_q != '0);
    assign out_data_o  = mem[rd_ptr_q];
    assign free_o      = CNT_W'(DEPTH) - count_q;

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge ACLK)
    begin
        if (push)
            mem[wr_ptr_q] <= in_data_i;
    end

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (pop)
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            if (push && !pop)
                count_q <= count_q + 1'b1;
            else if (pop && !push)
                count_q <= count_q - 1'b1;
        end
    end

endmodule

// ==== design/sram_req_if.sv ====
`timescale 1ns/1ps

// One engine's request for the shared SRAM port
interface sram_req_if;
    import sram_port_pkg::*;

    logic       req_valid;
    logic       grant;
    logic       we;
    sram_addr_t addr;
    sram_word_t wdata;
    sram_be_t   be;

    // Fields stay stable until req_valid and grant meet
    modport engine
    (
        output req_valid,
        output we,
        output addr,
        output wdata,
        output be,
        input  grant
    );

    modport arbiter
    (
        input  req_valid,
        input  we,
        input  addr,
        input  wdata,
        input  be,
        output grant
    );

endinterface

// ==== design/sram_port_pkg.sv ====
`include "axi_sram_settings.svh"

package sram_port_pkg;

    typedef logic [`AXI_DATA_W-1:0]   sram_word_t;
    typedef logic [`SRAM_ADDR_W-1:0]  sram_addr_t;
    typedef logic [`AXI_DATA_W/8-1:0] sram_be_t;

    // Byte address to word address shift
    localparam int WORD_BYTES_LOG2 = $clog2(`AXI_DATA_W / 8);

endpackage

// ==== design/axi_chan_pkg.sv ====
`include "axi_sram_settings.svh"

package axi_chan_pkg;

    typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [`AXI_ID_W-1:0]   axi_id_t;
    typedef logic [`AXI_LEN_W-1:0]  axi_len_t;
    typedef logic [1:0]             axi_resp_t;

    localparam axi_resp_t RESP_OKAY = 2'b00;

    // Shared by AW and AR, every burst is INCR with full-width beats
    typedef struct packed {
        axi_id_t   id;
        axi_addr_t addr;
        axi_len_t  len;
    } ax_beat_t;

    typedef struct packed {
        logic [`AXI_DATA_W-1:0]   data;
        logic [`AXI_DATA_W/8-1:0] strb;
        logic                     last;
    } w_beat_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } b_beat_t;

    typedef struct packed {
        axi_id_t                id;
        logic [`AXI_DATA_W-1:0] data;
        axi_resp_t              resp;
        logic                   last;
    } r_beat_t;

endpackage

// ==== design/axi_sram_settings.svh ====
`ifndef AXI_SRAM_SETTINGS_SVH
`define AXI_SRAM_SETTINGS_SVH

// AXI side widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_ID_W 4
`define AXI_LEN_W 8

// SRAM word address, 8K words of 32 bits
`define SRAM_ADDR_W 13

// Entries in each channel buffer
`define CHAN_FIFO_DEPTH 4

`endif
